//--- int_div_config.svh
/*
  build-time sizing for the iterative divider
  include wherever the word width or the step count is needed
*/
`ifndef INT_DIV_CONFIG_SVH
`define INT_DIV_CONFIG_SVH

// ------------------------------------------------------------
// datapath sizing
// ------------------------------------------------------------

// operand, quotient and remainder width
`define INT_DIV_WIDTH 32

// one quotient bit per iteration, so one step per operand bit
`define INT_DIV_STEPS `INT_DIV_WIDTH

// must hold INT_DIV_STEPS minus one
`define INT_DIV_CNT_WIDTH 5

`endif

//--- int_div_pkg.sv
/*
  shared types for the divider request and response
  import by wildcard inside a module body, or use scoped names in a port list
*/
`default_nettype none

`include "int_div_config.svh"

package int_div_pkg;

  // ------------------------------------------------------------
  // request function
  // ------------------------------------------------------------

  // signed means two's complement operands, result signs fixed up at the end
  typedef enum logic [0:0] {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_t;

  // ------------------------------------------------------------
  // data words
  // ------------------------------------------------------------

  // operands, quotient and remainder all share this width
  typedef logic [`INT_DIV_WIDTH-1:0] word_t;

  // remainder in the upper half, quotient in the lower half
  typedef struct packed {
    word_t rem;
    word_t quot;
  } result_t;

endpackage

`default_nettype wire

//--- int_div_ctrl_if.sv
/*
  control strobes and status between the divider FSM and its datapath
  the FSM side drives the strobes and the datapath side returns the trial sign
*/
`timescale 1ns/1ps
`default_nettype none

interface int_div_ctrl_if;

  // ------------------------------------------------------------
  // FSM to datapath
  // ------------------------------------------------------------

  // one cycle strobe that captures normalized operands and sign flags
  logic load_operands;

  // do one shift-subtract step this cycle
  logic iterate;

  // 1 keeps the difference and shifts in a quotient 1
  // 0 restores the shifted value and shifts in a quotient 0
  logic keep_diff;

  // ------------------------------------------------------------
  // datapath to FSM
  // ------------------------------------------------------------

  // sign of the trial subtraction, combinational from the registers
  logic sub_neg;

  modport fsm (
    output load_operands,
    output iterate,
    output keep_diff,
    input  sub_neg
  );

  modport dpath (
    input  load_operands,
    input  iterate,
    input  keep_diff,
    output sub_neg
  );

endinterface

`default_nettype wire

//--- int_div_step_counter.sv
/*
  down counter for the divider iterations
  load starts it at the step count minus one, last flags the final step
*/
`timescale 1ns/1ps
`default_nettype none

`include "int_div_config.svh"

module int_div_step_counter (
  input  wire  clk,
  input  wire  reset,
  input  wire  load,
  input  wire  dec,
  output logic last
);

  logic [`INT_DIV_CNT_WIDTH-1:0] count;

  // ------------------------------------------------------------
  // count register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      // steps are numbered down to zero
      count <= `INT_DIV_CNT_WIDTH'(`INT_DIV_STEPS - 1);
    end else if (dec) begin
      count <= count - 1'b1;
    end
  end

  // zero is the step that finishes the quotient
  assign last = (count == '0);

endmodule

`default_nettype wire

//--- int_div_fsm.sv
/*
  idle/calc/done sequencer for the iterative divider
  owns both handshakes, strobes the step counter and steers the datapath
*/
`timescale 1ns/1ps
`default_nettype none

module int_div_fsm (
  input  wire            clk,
  input  wire            reset,
  input  wire            req_val,
  input  wire            resp_rdy,
  output logic           req_rdy,
  output logic           resp_val,
  output logic           cnt_load,
  output logic           cnt_dec,
  input  wire            cnt_last,
  int_div_ctrl_if.fsm    ctrl
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } state_t;

  state_t state;
  state_t state_next;

  // ------------------------------------------------------------
  // state register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // next state
  // req_rdy is only high in idle, so req_val alone marks the accepting edge there
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (req_val) state_next = ST_CALC;
      // counter at zero means this is the final step
      ST_CALC: if (cnt_last) state_next = ST_DONE;
      // hold the response until the consumer takes it
      ST_DONE: if (resp_rdy) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------------------

  always_comb begin
    req_rdy            = 1'b0;
    resp_val           = 1'b0;
    cnt_load           = 1'b0;
    cnt_dec            = 1'b0;
    ctrl.load_operands = 1'b0;
    ctrl.iterate       = 1'b0;
    ctrl.keep_diff     = 1'b0;
    case (state)
      ST_IDLE: begin
        req_rdy            = 1'b1;
        // load everything on the accepting edge
        ctrl.load_operands = req_val;
        cnt_load           = req_val;
      end
      ST_CALC: begin
        ctrl.iterate   = 1'b1;
        cnt_dec        = 1'b1;
        // keep the difference only when the trial subtraction did not go negative
        ctrl.keep_diff = ~ctrl.sub_neg;
      end
      ST_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- int_div_dpath.sv
/*
  divider datapath with operand normalization, the restoring shift-subtract
  register pair and sign correction of quotient and remainder at the output
*/
`timescale 1ns/1ps
`default_nettype none

`include "int_div_config.svh"

module int_div_dpath (
  input  wire                  clk,
  input  wire                  reset,
  input  int_div_pkg::div_fn_t req_fn,
  input  int_div_pkg::word_t   req_a,
  input  int_div_pkg::word_t   req_b,
  int_div_ctrl_if.dpath        ctrl,
  output int_div_pkg::result_t resp_result
);

  import int_div_pkg::*;

  // ------------------------------------------------------------
  // operand normalization
  // ------------------------------------------------------------

  logic  is_signed;
  logic  a_neg;
  logic  b_neg;
  word_t a_mag;
  word_t b_mag;

  assign is_signed = (req_fn == DIV_FN_SIGNED);

  // only a signed request treats the top bit as a sign
  assign a_neg = is_signed & req_a[`INT_DIV_WIDTH-1];
  assign b_neg = is_signed & req_b[`INT_DIV_WIDTH-1];

  // two's complement magnitude
  // the most negative value maps onto itself, which reads as 2^(w-1) unsigned
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // ------------------------------------------------------------
  // shift-subtract registers
  // ------------------------------------------------------------

  // rq_reg holds {partial remainder, quotient} with one spare top bit for the shift
  logic [2*`INT_DIV_WIDTH:0] rq_reg;
  // divisor sits aligned with the remainder half
  logic [2*`INT_DIV_WIDTH:0] dvs_reg;
  logic [2*`INT_DIV_WIDTH:0] shifted;
  logic [2*`INT_DIV_WIDTH:0] diff;

  // result sign flags, captured with the operands
  logic quot_neg;
  logic rem_neg;

  assign shifted = rq_reg << 1;
  assign diff    = shifted - dvs_reg;

  // borrow out of the trial subtraction
  assign ctrl.sub_neg = diff[2*`INT_DIV_WIDTH];

  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (ctrl.load_operands) begin
      // quotient sign follows the xor of the operand signs
      quot_neg <= a_neg ^ b_neg;
      // remainder takes the sign of the dividend
      rem_neg  <= a_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_operands) begin
      rq_reg  <= {{(`INT_DIV_WIDTH + 1){1'b0}}, a_mag};
      dvs_reg <= {1'b0, b_mag, {`INT_DIV_WIDTH{1'b0}}};
    end else if (ctrl.iterate) begin
      // bit 0 of shifted is always zero, so it is free for the quotient bit
      if (ctrl.keep_diff) begin
        rq_reg <= {diff[2*`INT_DIV_WIDTH:1], 1'b1};
      end else begin
        rq_reg <= {shifted[2*`INT_DIV_WIDTH:1], 1'b0};
      end
    end
  end

  // ------------------------------------------------------------
  // sign correction
  // ------------------------------------------------------------

  word_t quot_mag;
  word_t rem_mag;

  // after the last step the remainder fits below the spare bit
  assign quot_mag = rq_reg[`INT_DIV_WIDTH-1:0];
  assign rem_mag  = rq_reg[2*`INT_DIV_WIDTH-1:`INT_DIV_WIDTH];

  assign resp_result.quot = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign resp_result.rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

endmodule

`default_nettype wire

//--- int_div_iterative.sv
/*
  iterative divider top level, valid/ready request in and response out
  one operation in flight, result ready 32 steps after the request is taken
*/
`timescale 1ns/1ps
`default_nettype none

module int_div_iterative (
  input  wire                  clk,
  input  wire                  reset,
  input  int_div_pkg::div_fn_t req_fn,
  input  int_div_pkg::word_t   req_a,
  input  int_div_pkg::word_t   req_b,
  input  wire                  req_val,
  output logic                 req_rdy,
  output int_div_pkg::result_t resp_result,
  output logic                 resp_val,
  input  wire                  resp_rdy
);

  // FSM to counter strobes and the final-step flag back
  logic cnt_load;
  logic cnt_dec;
  logic cnt_last;

  // FSM to datapath strobes and trial sign
  int_div_ctrl_if ctrl ();

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  int_div_fsm u_fsm (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .cnt_load (cnt_load),
    .cnt_dec  (cnt_dec),
    .cnt_last (cnt_last),
    .ctrl     (ctrl.fsm)
  );

  int_div_step_counter u_cnt (
    .clk   (clk),
    .reset (reset),
    .load  (cnt_load),
    .dec   (cnt_dec),
    .last  (cnt_last)
  );

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  int_div_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .ctrl        (ctrl.dpath),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

//--- int_div_checker.sv
/*
  handshake and reset assertions for the iterative divider
  bound onto the top level of the divider
*/
`timescale 1ns/1ps
`default_nettype none

module int_div_checker (
  input wire                  clk,
  input wire                  reset,
  input wire                  req_rdy,
  input wire                  resp_val,
  input wire                  resp_rdy,
  input int_div_pkg::result_t resp_result
);

  import int_div_pkg::*;

  // ------------------------------------------------------------
  // handshake rules
  // ------------------------------------------------------------

  // one operation in flight, so the two sides never overlap
  property p_no_overlap;
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val);
  endproperty

  // a stalled response keeps its valid and its data
  property p_resp_hold;
    @(posedge clk) disable iff (reset)
      (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result));
  endproperty

  // ------------------------------------------------------------
  // reset
  // ------------------------------------------------------------

  // idle is visible the cycle after a synchronous reset edge
  property p_reset_idle;
    @(posedge clk) reset |=> (req_rdy && !resp_val);
  endproperty

  a_no_overlap: assert property (p_no_overlap)
    else $error("req_rdy and resp_val are high together");

  a_resp_hold: assert property (p_resp_hold)
    else $error("response changed while stalled by resp_rdy");

  a_reset_idle: assert property (p_reset_idle)
    else $error("divider not idle after reset");

endmodule

// attach to every instance of the divider top
bind int_div_iterative int_div_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

//--- int_div_tb.sv
/*
  self-checking testbench for the iterative divider
  drives random and corner requests with back-pressure and checks them against an integer model
*/
`timescale 1ns/1ps
`default_nettype none

`include "int_div_config.svh"

module int_div_tb;

  import int_div_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_RANDOM   = 300;
  localparam int NUM_CORNER   = 6;
  // resp_val comes up this many edges after the accepting edge
  localparam int LATENCY      = `INT_DIV_STEPS;
  localparam int MAX_STALL    = 10;
  localparam int SLACK        = 8;
  localparam int TXN_TOTAL    = 2 * NUM_RANDOM + NUM_CORNER;
  localparam int WATCHDOG_NS  =
    (TXN_TOTAL * (LATENCY + 1 + MAX_STALL + SLACK) + RESET_CYCLES + 20) * CLK_PERIOD;

  localparam word_t ALL_ONES = '1;
  localparam word_t MOST_NEG = {1'b1, {($bits(word_t) - 1){1'b0}}};

  logic    clk;
  logic    reset;
  div_fn_t req_fn;
  word_t   req_a;
  word_t   req_b;
  logic    req_val;
  logic    req_rdy;
  result_t resp_result;
  logic    resp_val;
  logic    resp_rdy;

  integer seed;
  // handshakes as seen on the DUT ports
  int     req_count = 0;
  int     rsp_count = 0;

  int_div_iterative u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // count every request and response transfer edge
  always @(posedge clk) begin
    if (!reset && req_val && req_rdy) begin
      req_count <= req_count + 1;
    end
    if (!reset && resp_val && resp_rdy) begin
      rsp_count <= rsp_count + 1;
    end
  end

  // ------------------------------------------------------------
  // error handling and compares
  // ------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string msg);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s, got %b expected %b",
                          $time, msg, actual, expected));
    end
  endtask

  task automatic check_result(input result_t actual, input result_t expected,
                              input string msg);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s, quot %h exp %h, rem %h exp %h",
                          $time, msg, actual.quot, expected.quot,
                          actual.rem, expected.rem));
    end
  endtask

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // divide by zero gives all ones and the dividend back as remainder
  function automatic result_t model_divide(input div_fn_t fn, input word_t a, input word_t b);
    result_t r;
    logic    a_neg;
    logic    b_neg;
    word_t   am;
    word_t   bm;
    word_t   q;
    word_t   rm;
    a_neg = (fn == DIV_FN_SIGNED) && a[$bits(word_t) - 1];
    b_neg = (fn == DIV_FN_SIGNED) && b[$bits(word_t) - 1];
    am = a_neg ? -a : a;
    bm = b_neg ? -b : b;
    q  = (bm == '0) ? ALL_ONES : am / bm;
    rm = (bm == '0) ? am : am % bm;
    // quotient negative on differing signs, remainder follows the dividend
    r.quot = (a_neg ^ b_neg) ? -q : q;
    r.rem  = a_neg ? -rm : rm;
    return r;
  endfunction

  // biased toward 0, 1, all ones, most negative and small values
  function automatic word_t pick_operand();
    int sel;
    sel = $unsigned($random(seed)) % 8;
    case (sel)
      0:       return '0;
      1:       return word_t'(1);
      2:       return ALL_ONES;
      3:       return MOST_NEG;
      4:       return word_t'($unsigned($random(seed)) % 256);
      default: return word_t'($random(seed));
    endcase
  endfunction

  // ------------------------------------------------------------
  // one request/response transaction
  // ------------------------------------------------------------

  // entered and left 1 ns after a rising edge
  task automatic run_txn(input div_fn_t fn, input word_t a, input word_t b, input int stall);
    result_t exp;
    result_t held;
    int      edges;
    exp      = model_divide(fn, a, b);
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    // sample req_rdy mid-cycle until the accepting edge
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    check_flag(resp_val, 1'b0, "resp_val while ready for a request");
    @(posedge clk);
    #1;
    req_val = 1'b0;
    // operands only need to hold up to the accepting edge
    req_a   = word_t'($random(seed));
    req_b   = word_t'($random(seed));
    edges   = 0;
    @(negedge clk);
    while (!resp_val) begin
      check_flag(req_rdy, 1'b0, "req_rdy while busy");
      edges++;
      if (edges > LATENCY + 4) begin
        abort_run("no response from the divider after a request");
      end
      @(negedge clk);
    end
    if (edges != LATENCY) begin
      abort_run($sformatf("CHECK FAILED at %0t: latency %0d edges, expected %0d",
                          $time, edges, LATENCY));
    end
    check_result(resp_result, exp, "division result");
    held = resp_result;
    // stall the consumer side
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      if (i == stall - 1) resp_rdy = 1'b1;
      @(negedge clk);
      check_flag(resp_val, 1'b1, "resp_val dropped under back-pressure");
      check_result(resp_result, held, "result changed under back-pressure");
    end
    // response transfer edge
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    @(negedge clk);
    check_flag(resp_val, 1'b0, "second response after transfer");
    check_flag(req_rdy, 1'b1, "req_rdy after response transfer");
    @(posedge clk);
    #1;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin : main_seq
    word_t a;
    word_t b;
    int    stall;
    seed      = 71008;
    reset     = 1'b1;
    req_fn    = DIV_FN_UNSIGNED;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_flag(req_rdy, 1'b1, "req_rdy after reset");
    check_flag(resp_val, 1'b0, "resp_val after reset");
    @(posedge clk);
    #1;

    // unsigned then signed random traffic
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a     = pick_operand();
      b     = pick_operand();
      stall = $unsigned($random(seed)) % (MAX_STALL + 1);
      run_txn(DIV_FN_UNSIGNED, a, b, stall);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a     = pick_operand();
      b     = pick_operand();
      stall = $unsigned($random(seed)) % (MAX_STALL + 1);
      run_txn(DIV_FN_SIGNED, a, b, stall);
    end

    // corner values with both functions
    a = word_t'($random(seed));
    run_txn(DIV_FN_UNSIGNED, a, '0, 0);
    run_txn(DIV_FN_SIGNED, a, '0, 0);
    run_txn(DIV_FN_UNSIGNED, MOST_NEG, ALL_ONES, 0);
    run_txn(DIV_FN_SIGNED, MOST_NEG, ALL_ONES, 0);
    run_txn(DIV_FN_UNSIGNED, word_t'(5), word_t'(1000), 0);
    run_txn(DIV_FN_SIGNED, word_t'(5), word_t'(1000), 0);

    if (rsp_count == req_count && req_count == TXN_TOTAL) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("%0d requests and %0d responses, expected %0d of each",
               req_count, rsp_count, TXN_TOTAL);
      $display("STATUS: FAIL");
      $fatal(1, "transaction count mismatch");
    end
  end

  // watchdog sized from the transaction count and the worst-case cycle budget
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- int_div.f
+incdir+.
int_div_pkg.sv
int_div_ctrl_if.sv
int_div_step_counter.sv
int_div_fsm.sv
int_div_dpath.sv
int_div_iterative.sv
int_div_checker.sv
int_div_tb.sv

//--- Makefile
# Verilator build and run of the iterative divider testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= int_div_tb
FILELIST  ?= int_div.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= STATUS: FAIL
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
